// ==== memPkg.sv ====
package memPkg;

    // client side
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;

    // ram side, byte wide
    localparam int RamAddrWidth = 12;
    localparam int ByteWidth = 8;
    localparam int RamBytes = 1 << RamAddrWidth;

    // access length, legal values 1, 2 and 4
    localparam int LenWidth = 3;

    // byte counter inside one transfer
    localparam int StageWidth = 3;

    // a fetch is always a full word
    localparam logic [LenWidth-1:0] FetchLen = LenWidth'(WordWidth / ByteWidth);

    typedef enum logic [1:0] {
        Idle,
        ReadInst,
        ReadData,
        WriteData
    } ctrlState;

endpackage

// ==== memBus.sv ====
`timescale 1ns/1ps

interface memBus;
    import memPkg::*;

    logic                    en;
    logic                    write;
    logic [RamAddrWidth-1:0] addr;
    logic [ByteWidth-1:0]    wdata;
    // registered, valid the cycle after a read
    logic [ByteWidth-1:0]    rdata;

    modport ctrl (
        output en,
        output write,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  en,
        input  write,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          ioBufferFull,

    // instruction fetch client
    input  logic                          fetchEn,
    input  logic [memPkg::AddrWidth-1:0]  fetchAddr,
    output logic                          fetchDone,
    output logic [memPkg::WordWidth-1:0]  fetchInst,

    // data client
    input  logic                          dataEn,
    input  logic                          dataStore,
    input  logic [memPkg::LenWidth-1:0]   dataLen,
    input  logic [memPkg::AddrWidth-1:0]  dataAddr,
    input  logic [memPkg::WordWidth-1:0]  dataWrite,
    output logic                          dataDone,
    output logic [memPkg::WordWidth-1:0]  dataRead,

    memBus.ctrl                           mem
);
    import memPkg::*;

    ctrlState state;
    logic [StageWidth-1:0] stage;

    // request fields captured on acceptance
    logic [RamAddrWidth-1:0] baseAddr;
    logic [LenWidth-1:0]     lenQ;
    logic [WordWidth-1:0]    storeData;

    // bytes 0 .. n-2 of a read with the upper lanes left zero
    logic [WordWidth-1:0] partial;
    logic [WordWidth-1:0] lastByte;
    logic [WordWidth-1:0] assembled;

    logic stall;
    logic idleReady;
    logic dataAccept;
    logic fetchAccept;
    logic reading;
    logic readIssue;
    logic readFinish;
    logic lastWrite;

    // either global level freezes everything for one cycle
    assign stall = !rdy || ioBufferFull;

    assign idleReady = (state == Idle) && !stall;
    assign dataAccept = idleReady && dataEn;
    assign fetchAccept = idleReady && !dataEn && fetchEn;

    assign reading = (state == ReadInst) || (state == ReadData);

    // stage counts issued bytes and stage == len marks the done cycle
    assign readIssue = reading && (stage != lenQ) && !stall;
    assign readFinish = reading && (stage == lenQ) && !stall;
    assign lastWrite = (stage + 1'b1) == lenQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            stage <= '0;
        end else if (!stall) begin
            case (state)
                Idle: begin
                    stage <= '0;
                    if (dataEn) begin
                        state <= dataStore ? WriteData : ReadData;
                    end else if (fetchEn) begin
                        state <= ReadInst;
                    end
                end
                ReadInst, ReadData: begin
                    if (stage == lenQ) begin
                        state <= Idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                WriteData: begin
                    if (lastWrite) begin
                        state <= Idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
                default: begin
                    state <= Idle;
                    stage <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dataAccept) begin
            baseAddr <= dataAddr[RamAddrWidth-1:0];
            lenQ <= dataLen;
            storeData <= dataWrite;
            partial <= '0;
        end else if (fetchAccept) begin
            baseAddr <= fetchAddr[RamAddrWidth-1:0];
            lenQ <= FetchLen;
            partial <= '0;
        end else if (readIssue && (stage != '0)) begin
            // byte from the previous access is on rdata now
            partial[ByteWidth*(stage - 1'b1) +: ByteWidth] <= mem.rdata;
        end
    end

    // final byte goes straight from rdata into its lane
    always_comb begin
        lastByte = '0;
        case (lenQ)
            3'd1: lastByte[0 +: ByteWidth] = mem.rdata;
            3'd2: lastByte[ByteWidth +: ByteWidth] = mem.rdata;
            default: lastByte[WordWidth-ByteWidth +: ByteWidth] = mem.rdata;
        endcase
    end

    assign assembled = partial | lastByte;
    assign fetchInst = assembled;
    assign dataRead = assembled;

    assign fetchDone = readFinish && (state == ReadInst);
    assign dataDone = (readFinish && (state == ReadData))
                   || ((state == WriteData) && lastWrite && !stall);

    // one byte per active cycle in little-endian order
    assign mem.en = !stall && (readIssue || (state == WriteData));
    assign mem.write = !stall && (state == WriteData);
    assign mem.addr = baseAddr + RamAddrWidth'(stage);
    assign mem.wdata = storeData[ByteWidth*stage +: ByteWidth];

    doneEndsTransfer: assert property (
        @(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> (state == Idle)
    );

    // every access stays inside the requested length
    accessInsideLength: assert property (
        @(posedge clk) disable iff (rst)
        mem.en |-> (stage < lenQ)
    );

    legalDataLen: assert property (
        @(posedge clk) disable iff (rst)
        dataAccept |-> (dataLen inside {3'd1, 3'd2, 3'd4})
    );

endmodule

// ==== byteRam.sv ====
`timescale 1ns/1ps

module byteRam (
    input logic clk,
    memBus.ram  mem
);
    import memPkg::*;

    logic [ByteWidth-1:0] bytes [RamBytes];

    // rdata only moves on an enabled read, otherwise it holds
    always_ff @(posedge clk) begin
        if (mem.en) begin
            if (mem.write) begin
                bytes[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= bytes[mem.addr];
            end
        end
    end

    writeNeedsEnable: assert property (
        @(posedge clk)
        mem.write |-> mem.en
    );

endmodule

// ==== memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          ioBufferFull,

    input  logic                          fetchEn,
    input  logic [memPkg::AddrWidth-1:0]  fetchAddr,
    output logic                          fetchDone,
    output logic [memPkg::WordWidth-1:0]  fetchInst,

    input  logic                          dataEn,
    input  logic                          dataStore,
    input  logic [memPkg::LenWidth-1:0]   dataLen,
    input  logic [memPkg::AddrWidth-1:0]  dataAddr,
    input  logic [memPkg::WordWidth-1:0]  dataWrite,
    output logic                          dataDone,
    output logic [memPkg::WordWidth-1:0]  dataRead
);

    // controller to ram link
    memBus bus ();

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWrite    (dataWrite),
        .dataDone     (dataDone),
        .dataRead     (dataRead),
        .mem          (bus)
    );

    byteRam ram (
        .clk (clk),
        .mem (bus)
    );

endmodule

// ==== memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;
    import memPkg::*;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 10;
    localparam int CyclesPerLine = 40;
    localparam logic [31:0] Seed = 32'h4def7303;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    logic ioBufferFull;

    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [WordWidth-1:0] fetchInst;

    logic                 dataEn;
    logic                 dataStore;
    logic [LenWidth-1:0]  dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [WordWidth-1:0] dataWrite;
    logic                 dataDone;
    logic [WordWidth-1:0] dataRead;

    // one entry per transaction line of the stimulus file
    logic [7:0]  kinds [$];
    logic [31:0] addrs [$];
    logic [31:0] lens [$];
    logic [31:0] wdatas [$];
    logic [31:0] expVals [$];
    logic [31:0] stallFlags [$];

    int numLines = 0;
    int checkErrors = 0;
    int monitorErrors = 0;
    logic stallsOn = 1'b0;

    memSubsystem memSubsystem_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWrite    (dataWrite),
        .dataDone     (dataDone),
        .dataRead     (dataRead)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // each stall level is active about one cycle in six
    initial begin : stallDriver
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        void'($urandom(Seed));
        forever begin
            @(posedge clk);
            if (stallsOn) begin
                rdy <= ($urandom % 6) != 0;
                ioBufferFull <= ($urandom % 6) == 0;
            end else begin
                rdy <= 1'b1;
                ioBufferFull <= 1'b0;
            end
        end
    end

    // sampled mid cycle where outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(fetchDone && dataDone)) else begin
                $display("fetchDone and dataDone both high at %0t", $time);
                monitorErrors++;
            end
            assert (!((fetchDone || dataDone) && (!rdy || ioBufferFull))) else begin
                $display("done pulse in a stall cycle at %0t", $time);
                monitorErrors++;
            end
        end
    end

    initial begin : watchdog
        wait (numLines != 0);
        #((numLines * CyclesPerLine + ResetCycles) * ClkPeriod);
        $display("timeout: the transactions did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic loadStimulus(output bit ok);
        int fd;
        int fields;
        string line;
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [31:0] len;
        logic [31:0] wdata;
        logic [31:0] expVal;
        logic [31:0] stall;
        ok = 1'b0;
        fd = $fopen("memStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open memStimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h %h", kind, addr, len, wdata, expVal, stall);
            if (fields != 6) begin
                $display("malformed stimulus line: %s", line);
                checkErrors++;
                continue;
            end
            kinds.push_back(kind);
            addrs.push_back(addr);
            lens.push_back(len);
            wdatas.push_back(wdata);
            expVals.push_back(expVal);
            stallFlags.push_back(stall);
        end
        $fclose(fd);
        ok = (kinds.size() != 0);
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            checkErrors++;
        end
    endtask

    task automatic runTransaction(input int idx);
        logic [7:0]  kind;
        logic [31:0] len;
        bit isStore;
        bit needData;
        bit needFetch;
        bit gotData;
        bit gotFetch;
        int cycles;
        int dataCycle;
        int fetchCycle;
        int expLatency;
        int seenLatency;
        kind = kinds[idx];
        len = lens[idx];
        isStore = (kind == "S");
        needData = (kind != "F");
        needFetch = (kind == "F") || (kind == "B");
        // the stall driver reads this at the drive edge
        @(negedge clk);
        stallsOn = (stallFlags[idx] != 0);
        @(posedge clk);
        if (needData) begin
            dataEn <= 1'b1;
            dataStore <= isStore;
            dataLen <= len[LenWidth-1:0];
            dataAddr <= addrs[idx];
            dataWrite <= wdatas[idx];
        end
        if (needFetch) begin
            fetchEn <= 1'b1;
            fetchAddr <= addrs[idx];
        end
        gotData = !needData;
        gotFetch = !needFetch;
        cycles = 0;
        dataCycle = 0;
        fetchCycle = 0;
        while (!(gotData && gotFetch)) begin
            @(negedge clk);
            cycles++;
            if (dataDone) begin
                assert (!gotData) else begin
                    $display("dataDone pulsed with no data request pending at %0t", $time);
                    checkErrors++;
                end
                if (!gotData) begin
                    gotData = 1'b1;
                    dataCycle = cycles;
                    if (!isStore) begin
                        checkWord("dataRead", expVals[idx], dataRead);
                    end
                end
            end
            if (fetchDone) begin
                assert (!gotFetch) else begin
                    $display("fetchDone pulsed with no fetch pending at %0t", $time);
                    checkErrors++;
                end
                if (!gotFetch) begin
                    gotFetch = 1'b1;
                    fetchCycle = cycles;
                    // B lines carry the fetch word in the write data column
                    checkWord("fetchInst", (kind == "B") ? wdatas[idx] : expVals[idx],
                              fetchInst);
                end
            end
            // drop at the edge that ends the done cycle
            @(posedge clk);
            if (gotData) begin
                dataEn <= 1'b0;
            end
            if (gotFetch) begin
                fetchEn <= 1'b0;
            end
        end
        if (kind == "B") begin
            assert (dataCycle < fetchCycle) else begin
                $display("fetch served before the data load on line %0d at %0t", idx, $time);
                checkErrors++;
            end
        end
        if (stallFlags[idx] == 0) begin
            // a store is done in its last write cycle and a read one cycle after its last access
            expLatency = isStore ? int'(len) : int'(len) + 1;
            seenLatency = ((kind == "F") ? fetchCycle : dataCycle) - 1;
            assert (seenLatency == expLatency) else begin
                $display("ERR %0t done latency expected %0d got %0d", $time,
                         expLatency, seenLatency);
                checkErrors++;
            end
        end
    endtask

    initial begin : mainFlow
        bit loaded;
        rst = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWrite = '0;
        loadStimulus(loaded);
        if (!loaded) begin
            $display("no usable transactions in memStimulus.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            numLines = kinds.size();
            repeat (ResetCycles) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < numLines; i++) begin
                runTransaction(i);
            end
            @(negedge clk);
            stallsOn = 1'b0;
            repeat (4) @(posedge clk);
            $display("errors: checks %0d, monitor %0d", checkErrors, monitorErrors);
            if (checkErrors + monitorErrors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== memStimulus.txt ====
# kind addr len wdata expected stall, all hex; S store, L load, F fetch, B load and fetch
# on B lines wdata is the expected fetch word; stall 1 turns random stalls on for the line
S 000 4 11223344 00000000 0
S 004 4 55667788 00000000 1
S 008 4 deadbeef 00000000 1
S 00c 4 cafef00d 00000000 0
S 010 1 000000a5 00000000 0
S 011 1 0000005a 00000000 1
S 012 2 00001234 00000000 1
S 7fe 2 0000beef 00000000 0
S 800 4 89abcdef 00000000 1
S ffc 4 01020304 00000000 1
L 000 4 00000000 11223344 0
L 004 4 00000000 55667788 1
L 008 4 00000000 deadbeef 1
L 00c 4 00000000 cafef00d 0
L 010 4 00000000 12345aa5 1
L 001 1 00000000 00000033 1
L 002 2 00000000 00001122 1
L 003 2 00000000 00008811 1
L 009 2 00000000 0000adbe 1
L 00e 1 00000000 000000fe 0
L 7fe 2 00000000 0000beef 0
L 7ff 2 00000000 0000efbe 1
L 005 4 00000000 ef556677 1
L ffe 2 00000000 00000102 1
L 010 1 00000000 000000a5 0
F 000 4 00000000 11223344 0
F 008 4 00000000 deadbeef 1
F 002 4 00000000 77881122 1
F 800 4 00000000 89abcdef 1
F ffc 4 00000000 01020304 1
F 00c 4 00000000 cafef00d 0
B 004 4 55667788 55667788 0
B 000 1 11223344 00000044 1
B 00c 2 cafef00d 0000f00d 1
B 800 2 89abcdef 0000cdef 1
B 006 2 beef5566 00005566 0
S 000 4 a1b2c3d4 00000000 1
L 000 4 00000000 a1b2c3d4 1
L 001 2 00000000 0000b2c3 1
L 003 1 00000000 000000a1 1
F 000 4 00000000 a1b2c3d4 1
L 002 4 00000000 7788a1b2 1
S 001 1 000000ff 00000000 0
L 000 4 00000000 a1b2ffd4 0

// ==== all.f ====
memPkg.sv
memBus.sv
memCtrl.sv
byteRam.sv
memSubsystem.sv
memSubsystemTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module memSubsystemTb -f all.f -o memSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/memSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
